//--- dec_pkg.sv
// RV32IM decode types only; branches, jumps, A/B extensions and operand selects are not encoded
package dec_pkg;

  ////////////////////////////////////////
  // Opcode and function fields
  ////////////////////////////////////////
  typedef logic [6:0] opcode_t;                 // Major opcode, instr[6:0]

  localparam opcode_t OPC_OP      = 7'h33;      // Register-register ALU
  localparam opcode_t OPC_OPIMM   = 7'h13;      // Register-immediate ALU
  localparam opcode_t OPC_LOAD    = 7'h03;
  localparam opcode_t OPC_STORE   = 7'h23;
  localparam opcode_t OPC_LUI     = 7'h37;
  localparam opcode_t OPC_AUIPC   = 7'h17;
  localparam opcode_t OPC_SYSTEM  = 7'h73;      // ECALL, EBREAK, MRET, WFI, CSR
  localparam opcode_t OPC_MISCMEM = 7'h0f;      // FENCE, FENCE.I

  localparam logic [6:0] FUNCT7_BASE   = 7'h00; // Plain ALU op
  localparam logic [6:0] FUNCT7_ALT    = 7'h20; // SUB and SRA
  localparam logic [6:0] FUNCT7_MULDIV = 7'h01; // RV32M

  // Fully specified SYSTEM words
  localparam logic [31:0] INSTR_ECALL  = 32'h0000_0073;
  localparam logic [31:0] INSTR_EBREAK = 32'h0010_0073;
  localparam logic [31:0] INSTR_MRET   = 32'h3020_0073;
  localparam logic [31:0] INSTR_WFI    = 32'h1050_0073;

  ////////////////////////////////////////
  // Vector types and operator enums
  ////////////////////////////////////////
  typedef logic [31:0] instr_t;                 // Uncompressed instruction word
  typedef logic [1:0]  lsu_size_t;              // 0 byte, 1 halfword, 2 word

  typedef enum logic [3:0] {ADD, SUB, SLL, SLT, SLTU, XOR, SRL, SRA, OR, AND} alu_op_e;
  typedef enum logic [1:0] {MUL, MULH, MULHSU, MULHU} mul_op_e;  // funct3 0..3 order
  typedef enum logic [1:0] {DIV, DIVU, REM, REMU} div_op_e;      // funct3 4..7 order
  typedef enum logic [1:0] {CSR_READ, CSR_WRITE, CSR_SET, CSR_CLEAR} csr_op_e;

  ////////////////////////////////////////
  // Pipe structs
  ////////////////////////////////////////
  typedef struct packed {
    logic      alu_en;
    logic      mul_en;
    logic      div_en;
    logic      lsu_en;
    logic      csr_en;
    logic      sys_en;
    logic      rf_we;
    alu_op_e   alu_operator;
    mul_op_e   mul_operator;
    div_op_e   div_operator;
    csr_op_e   csr_op;
    logic      lsu_we;
    lsu_size_t lsu_size;
    logic      lsu_sext;
    logic [1:0] rf_re;                          // Bit 0 rs1, bit 1 rs2
    logic      sys_ecall;
    logic      sys_ebrk;
    logic      sys_mret;
    logic      sys_wfi;
    logic      sys_fencei;
    logic      illegal_insn;
  } decoder_ctrl_t;

  typedef struct packed {
    logic   valid;
    instr_t instr;
    logic   illegal_c_insn;                     // Set by the compressed expander
  } if_id_pipe_t;

  typedef struct packed {
    logic          valid;
    decoder_ctrl_t ctrl;
  } id_ex_pipe_t;

  // No-match result of every sub-decoder
  localparam decoder_ctrl_t DECODER_CTRL_ILLEGAL_INSN = '{
    alu_en: 1'b0, mul_en: 1'b0, div_en: 1'b0, lsu_en: 1'b0, csr_en: 1'b0,
    sys_en: 1'b0, rf_we: 1'b0,
    alu_operator: ADD, mul_operator: MUL, div_operator: DIV, csr_op: CSR_READ,
    lsu_we: 1'b0, lsu_size: 2'd0, lsu_sext: 1'b0, rf_re: 2'b00,
    sys_ecall: 1'b0, sys_ebrk: 1'b0, sys_mret: 1'b0, sys_wfi: 1'b0, sys_fencei: 1'b0,
    illegal_insn: 1'b1
  };

  // Same word with illegal_insn cleared; bubbles, reset and decode start point
  localparam decoder_ctrl_t DECODER_CTRL_IDLE = '{
    alu_en: 1'b0, mul_en: 1'b0, div_en: 1'b0, lsu_en: 1'b0, csr_en: 1'b0,
    sys_en: 1'b0, rf_we: 1'b0,
    alu_operator: ADD, mul_operator: MUL, div_operator: DIV, csr_op: CSR_READ,
    lsu_we: 1'b0, lsu_size: 2'd0, lsu_sext: 1'b0, rf_re: 2'b00,
    sys_ecall: 1'b0, sys_ebrk: 1'b0, sys_mret: 1'b0, sys_wfi: 1'b0, sys_fencei: 1'b0,
    illegal_insn: 1'b0
  };

endpackage

//--- if_id_stage.sv
// Fetch-side register; captures on every edge, no stall, a low valid just marks a bubble
`timescale 1ns/10ps

module if_id_stage import dec_pkg::*; (
  input  logic        clk_i,
  input  logic        rst_n_i,          // Async, active low
  input  logic        instr_valid_i,    // Plain strobe from fetch
  input  instr_t      instr_i,          // Fetched word
  input  logic        illegal_c_i,      // Expander found a bad compressed encoding
  output if_id_pipe_t if_id_pipe_o      // Held for one ID cycle
);

  ////////////////////////////////////////
  // IF/ID register
  ////////////////////////////////////////

  // Invalid zero word after reset
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      if_id_pipe_o.valid          <= 1'b0;
      if_id_pipe_o.instr          <= '0;
      if_id_pipe_o.illegal_c_insn <= 1'b0;
    end else begin
      if_id_pipe_o.valid          <= instr_valid_i;  // Bubble when low
      if_id_pipe_o.instr          <= instr_i;
      if_id_pipe_o.illegal_c_insn <= illegal_c_i;    // Travels with its word
    end
  end

endmodule

//--- i_decoder.sv
// RV32I base decode only; branches and jumps come out illegal, CSR ops are decoded but not run
`timescale 1ns/10ps

module i_decoder import dec_pkg::*; (
  input  instr_t        instr_rdata_i,   // Word from IF/ID
  output decoder_ctrl_t decoder_ctrl_o   // illegal_insn set when nothing matches
);

  opcode_t    opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  logic [4:0] rs1;                       // Also the CSR uimm field
  logic       legal_op;
  logic       legal_opimm;

  assign opcode = instr_rdata_i[6:0];
  assign funct3 = instr_rdata_i[14:12];
  assign funct7 = instr_rdata_i[31:25];
  assign rs1    = instr_rdata_i[19:15];

  // funct7 0x20 only exists for SUB and SRA
  assign legal_op = (funct7 == FUNCT7_BASE) ||
                    ((funct7 == FUNCT7_ALT) && ((funct3 == 3'd0) || (funct3 == 3'd5)));

  // Shift immediates reuse funct7, the rest carry imm bits there
  assign legal_opimm = (funct3 == 3'd1) ? (funct7 == FUNCT7_BASE) :
                       (funct3 == 3'd5) ? ((funct7 == FUNCT7_BASE) || (funct7 == FUNCT7_ALT)) :
                       1'b1;

  // funct3 to ALU operator, alt picks SUB or SRA
  function automatic alu_op_e alu_op(input logic [2:0] f3, input logic alt);
    alu_op_e op;
    case (f3)
      3'd0:    op = alt ? SUB : ADD;
      3'd1:    op = SLL;
      3'd2:    op = SLT;
      3'd3:    op = SLTU;
      3'd4:    op = XOR;
      3'd5:    op = alt ? SRA : SRL;
      3'd6:    op = OR;
      default: op = AND;
    endcase
    return op;
  endfunction

  ////////////////////////////////////////
  // Decode by major opcode
  ////////////////////////////////////////
  always_comb begin
    decoder_ctrl_o = DECODER_CTRL_IDLE;            // Start legal, knock out below
    case (opcode)
      OPC_OP: begin
        decoder_ctrl_o.alu_en       = 1'b1;
        decoder_ctrl_o.rf_we        = 1'b1;
        decoder_ctrl_o.rf_re        = 2'b11;       // rs1 and rs2
        decoder_ctrl_o.alu_operator = alu_op(funct3, funct7[5]);
        if (!legal_op) decoder_ctrl_o = DECODER_CTRL_ILLEGAL_INSN;
      end
      OPC_OPIMM: begin
        decoder_ctrl_o.alu_en       = 1'b1;
        decoder_ctrl_o.rf_we        = 1'b1;
        decoder_ctrl_o.rf_re        = 2'b01;       // rs1 only
        // imm[10] only means SRAI for funct3 5, ADDI stays ADD
        decoder_ctrl_o.alu_operator = alu_op(funct3, funct7[5] && (funct3 == 3'd5));
        if (!legal_opimm) decoder_ctrl_o = DECODER_CTRL_ILLEGAL_INSN;
      end
      OPC_LUI, OPC_AUIPC: begin
        decoder_ctrl_o.alu_en       = 1'b1;        // Immediate plus zero or PC
        decoder_ctrl_o.rf_we        = 1'b1;
        decoder_ctrl_o.alu_operator = ADD;
      end
      OPC_LOAD: begin
        decoder_ctrl_o.lsu_en   = 1'b1;
        decoder_ctrl_o.rf_we    = 1'b1;
        decoder_ctrl_o.rf_re    = 2'b01;
        decoder_ctrl_o.lsu_size = funct3[1:0];
        decoder_ctrl_o.lsu_sext = !funct3[2];      // LBU and LHU zero extend
        if ((funct3 == 3'd3) || (funct3 > 3'd5)) decoder_ctrl_o = DECODER_CTRL_ILLEGAL_INSN;
      end
      OPC_STORE: begin
        decoder_ctrl_o.lsu_en   = 1'b1;
        decoder_ctrl_o.lsu_we   = 1'b1;
        decoder_ctrl_o.rf_re    = 2'b11;           // Address base and store data
        decoder_ctrl_o.lsu_size = funct3[1:0];
        if (funct3 > 3'd2) decoder_ctrl_o = DECODER_CTRL_ILLEGAL_INSN;
      end
      OPC_SYSTEM: begin
        if (funct3 == 3'd0) begin
          decoder_ctrl_o.sys_en = 1'b1;
          case (instr_rdata_i)                     // Exact match, no don't-care bits
            INSTR_ECALL:  decoder_ctrl_o.sys_ecall = 1'b1;
            INSTR_EBREAK: decoder_ctrl_o.sys_ebrk  = 1'b1;
            INSTR_MRET:   decoder_ctrl_o.sys_mret  = 1'b1;
            INSTR_WFI:    decoder_ctrl_o.sys_wfi   = 1'b1;
            default:      decoder_ctrl_o = DECODER_CTRL_ILLEGAL_INSN;
          endcase
        end else if (funct3 == 3'd4) begin
          decoder_ctrl_o = DECODER_CTRL_ILLEGAL_INSN;
        end else begin
          decoder_ctrl_o.csr_en = 1'b1;
          decoder_ctrl_o.rf_we  = 1'b1;            // Old CSR value to rd
          decoder_ctrl_o.rf_re  = funct3[2] ? 2'b00 : 2'b01;  // uimm forms read no reg
          case (funct3[1:0])
            2'd1:    decoder_ctrl_o.csr_op = CSR_WRITE;
            2'd2:    decoder_ctrl_o.csr_op = (rs1 == 5'd0) ? CSR_READ : CSR_SET;
            default: decoder_ctrl_o.csr_op = (rs1 == 5'd0) ? CSR_READ : CSR_CLEAR;
          endcase
        end
      end
      OPC_MISCMEM: begin
        if (funct3 == 3'd1) begin
          decoder_ctrl_o.sys_en     = 1'b1;
          decoder_ctrl_o.sys_fencei = 1'b1;
        end else if (funct3 != 3'd0) begin        // FENCE is a legal no-op
          decoder_ctrl_o = DECODER_CTRL_ILLEGAL_INSN;
        end
      end
      default: decoder_ctrl_o = DECODER_CTRL_ILLEGAL_INSN;  // Branches, jumps, unknown
    endcase
  end

endmodule

//--- m_decoder.sv
// RV32M decode only; matches OP with funct7 0x01, anything else returns the illegal word
`timescale 1ns/10ps

module m_decoder import dec_pkg::*; (
  input  instr_t        instr_rdata_i,   // Word from IF/ID
  output decoder_ctrl_t decoder_ctrl_o   // illegal_insn set when not RV32M
);

  logic [2:0] funct3;
  logic       match;

  assign funct3 = instr_rdata_i[14:12];
  assign match  = (instr_rdata_i[6:0] == OPC_OP) && (instr_rdata_i[31:25] == FUNCT7_MULDIV);

  always_comb begin
    decoder_ctrl_o = DECODER_CTRL_ILLEGAL_INSN;
    if (match) begin
      decoder_ctrl_o       = DECODER_CTRL_IDLE;
      decoder_ctrl_o.rf_we = 1'b1;
      decoder_ctrl_o.rf_re = 2'b11;              // Both sources always read
      if (funct3[2]) begin
        decoder_ctrl_o.div_en       = 1'b1;
        decoder_ctrl_o.div_operator = div_op_e'(funct3[1:0]);  // DIV DIVU REM REMU
      end else begin
        decoder_ctrl_o.mul_en       = 1'b1;
        decoder_ctrl_o.mul_operator = mul_op_e'(funct3[1:0]);  // MUL MULH MULHSU MULHU
      end
    end
  end

endmodule

//--- decoder.sv
// Combinational ID decode; no operand selects or register addresses, suppression is level based
`timescale 1ns/10ps

module decoder import dec_pkg::*; #(
  parameter bit M_EXT = 1'b1              // Build the RV32M sub-decoder
) (
  input  if_id_pipe_t   if_id_pipe_i,     // Word and flags in ID
  input  logic          deassert_we_i,    // Controller kills this ID instruction
  output logic          valid_o,          // Stage valid, passed through
  output decoder_ctrl_t decoder_ctrl_o    // Final, suppressed controls
);

  decoder_ctrl_t i_ctrl;                  // RV32I result
  decoder_ctrl_t m_ctrl;                  // RV32M result or illegal default
  decoder_ctrl_t mux_subdec;              // Winner among sub-decoders
  decoder_ctrl_t mux_ctrl;                // After the compressed override

  ////////////////////////////////////////
  // Sub-decoders
  ////////////////////////////////////////
  i_decoder u_i_decoder (
    .instr_rdata_i  (if_id_pipe_i.instr),
    .decoder_ctrl_o (i_ctrl)
  );

  generate
    if (M_EXT) begin : gen_m_decoder
      m_decoder u_m_decoder (
        .instr_rdata_i  (if_id_pipe_i.instr),
        .decoder_ctrl_o (m_ctrl)
      );
    end else begin : gen_no_m_decoder
      assign m_ctrl = DECODER_CTRL_ILLEGAL_INSN;  // Never matches
    end
  endgenerate

  // M first, then I, otherwise illegal
  always_comb begin
    if (!m_ctrl.illegal_insn) begin
      mux_subdec = m_ctrl;
    end else if (!i_ctrl.illegal_insn) begin
      mux_subdec = i_ctrl;
    end else begin
      mux_subdec = DECODER_CTRL_ILLEGAL_INSN;
    end
  end

  // Bad compressed encoding beats whatever the expanded word decodes to
  assign mux_ctrl = if_id_pipe_i.illegal_c_insn ? DECODER_CTRL_ILLEGAL_INSN : mux_subdec;

  ////////////////////////////////////////
  // Suppression
  ////////////////////////////////////////
  always_comb begin
    decoder_ctrl_o = mux_ctrl;                      // Operators always pass
    if (deassert_we_i) begin
      decoder_ctrl_o.alu_en       = 1'b0;
      decoder_ctrl_o.mul_en       = 1'b0;
      decoder_ctrl_o.div_en       = 1'b0;
      decoder_ctrl_o.lsu_en       = 1'b0;
      decoder_ctrl_o.csr_en       = 1'b0;
      decoder_ctrl_o.sys_en       = 1'b0;
      decoder_ctrl_o.rf_we        = 1'b0;
      decoder_ctrl_o.lsu_we       = 1'b0;         // Memory write is a write enable too
      decoder_ctrl_o.illegal_insn = 1'b0;         // No trap for a killed instruction
    end
  end

  assign valid_o = if_id_pipe_i.valid;

endmodule

//--- id_ex_stage.sv
// Execute-side register; loads the idle word on bubbles so no enable reaches execute
`timescale 1ns/10ps

module id_ex_stage import dec_pkg::*; (
  input  logic          clk_i,
  input  logic          rst_n_i,          // Async, active low
  input  logic          valid_i,          // ID stage valid
  input  decoder_ctrl_t decoder_ctrl_i,   // Already suppressed
  output id_ex_pipe_t   id_ex_pipe_o      // Controls for execute
);

  ////////////////////////////////////////
  // ID/EX register
  ////////////////////////////////////////
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      id_ex_pipe_o.valid <= 1'b0;
      id_ex_pipe_o.ctrl  <= DECODER_CTRL_IDLE;   // All enables low
    end else begin
      id_ex_pipe_o.valid <= valid_i;
      // Bubble still registers, just with nothing enabled
      id_ex_pipe_o.ctrl  <= valid_i ? decoder_ctrl_i : DECODER_CTRL_IDLE;
    end
  end

endmodule

//--- decode_top.sv
// Decode slice top; fixed 2-edge latency from instr_valid_i to id_ex_pipe_o, no back-pressure
`timescale 1ns/10ps

module decode_top import dec_pkg::*; (
  input  logic        clk_i,
  input  logic        rst_n_i,
  input  logic        instr_valid_i,
  input  instr_t      instr_i,
  input  logic        illegal_c_i,
  input  logic        deassert_we_i,    // Level, applies to the word in ID
  output id_ex_pipe_t id_ex_pipe_o
);

  if_id_pipe_t   if_id_pipe;            // IF/ID register contents
  logic          id_valid;              // ID stage valid
  decoder_ctrl_t id_ctrl;               // Decoded, suppressed controls

  if_id_stage u_if_id_stage (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .instr_valid_i (instr_valid_i),
    .instr_i       (instr_i),
    .illegal_c_i   (illegal_c_i),
    .if_id_pipe_o  (if_id_pipe)
  );

  decoder u_decoder (
    .if_id_pipe_i   (if_id_pipe),
    .deassert_we_i  (deassert_we_i),
    .valid_o        (id_valid),
    .decoder_ctrl_o (id_ctrl)
  );

  id_ex_stage u_id_ex_stage (
    .clk_i          (clk_i),
    .rst_n_i        (rst_n_i),
    .valid_i        (id_valid),
    .decoder_ctrl_i (id_ctrl),
    .id_ex_pipe_o   (id_ex_pipe_o)
  );

endmodule

//--- decode_assert.sv
// Checks only the ID/EX outputs of decode_top; samples on the rising clock, bound by module name
`timescale 1ns/10ps

module decode_assert import dec_pkg::*; (
  input logic        clk_i,
  input logic        rst_n_i,
  input id_ex_pipe_t id_ex_pipe_o     // Observed DUT output
);

  logic en_any;                       // Any unit or write enable

  assign en_any = id_ex_pipe_o.ctrl.alu_en | id_ex_pipe_o.ctrl.mul_en |
                  id_ex_pipe_o.ctrl.div_en | id_ex_pipe_o.ctrl.lsu_en |
                  id_ex_pipe_o.ctrl.csr_en | id_ex_pipe_o.ctrl.sys_en |
                  id_ex_pipe_o.ctrl.rf_we  | id_ex_pipe_o.ctrl.lsu_we;

  // Bubbles carry nothing into execute
  a_bubble_idle: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    !id_ex_pipe_o.valid |-> !en_any)
    else $error("enable set on a bubble");

  a_muldiv_excl: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    !(id_ex_pipe_o.ctrl.mul_en && id_ex_pipe_o.ctrl.div_en))
    else $error("mul_en and div_en together");

  a_we_needs_en: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    id_ex_pipe_o.ctrl.lsu_we |-> id_ex_pipe_o.ctrl.lsu_en)
    else $error("lsu_we without lsu_en");

  // Async reset, so idle is already visible at the edge
  a_reset_idle: assert property (@(posedge clk_i)
    !rst_n_i |-> (!id_ex_pipe_o.valid && !en_any && !id_ex_pipe_o.ctrl.illegal_insn))
    else $error("outputs not idle in reset");

endmodule

bind decode_top decode_assert u_decode_assert (
  .clk_i        (clk_i),
  .rst_n_i      (rst_n_i),
  .id_ex_pipe_o (id_ex_pipe_o)
);

//--- tb_decode.sv
// Directed and LFSR tests of decode_top; expects a fixed 2-edge latency and no back-pressure
`timescale 1ns/10ps

module tb_decode import dec_pkg::*; ();

  localparam int N_DIRECTED = 80;                // Upper bound on directed words
  localparam int N_RAND     = 200;               // Random stream length
  localparam int N_ISSUE    = N_DIRECTED + N_RAND + 6 * 6;  // Plus drain per test

  logic        clk_i;
  logic        rst_n_i;
  logic        instr_valid_i;
  instr_t      instr_i;
  logic        illegal_c_i;
  logic        deassert_we_i;
  id_ex_pipe_t id_ex_pipe_o;

  id_ex_pipe_t exp_q[$];                         // Expected outputs in order
  int          due_q[$];                         // Cycle each one is due
  int          cycle = 0;
  int          n_checks = 0;
  int          n_err = 0;
  int          n_tests = 0;
  int          test_err;
  logic        prev_kill = 1'b0;                 // Deassert for the word now in ID
  logic [31:0] lfsr = 32'h1d6a;

  decode_top UUT (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .instr_valid_i (instr_valid_i),
    .instr_i       (instr_i),
    .illegal_c_i   (illegal_c_i),
    .deassert_we_i (deassert_we_i),
    .id_ex_pipe_o  (id_ex_pipe_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #20 clk_i = ~clk_i;                  // 40 ns period
  end

  always @(posedge clk_i) cycle <= cycle + 1;

  // Watchdog sized from the test lengths
  initial begin
    #((N_ISSUE + 20) * 40);
    $display("Timeout: expected results still pending after %0t", $time);
    $display("** FAIL **");
    $finish;
  end

  ////////////////////////////////////////
  // Stimulus helpers
  ////////////////////////////////////////
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    logic        fb;
    r = '0;
    for (int k = 0; k < n; k++) begin
      fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];  // Taps 32 22 2 1
      lfsr = {lfsr[30:0], fb};
      r    = {r[30:0], fb};
    end
    return r;
  endfunction

  function automatic instr_t enc_r(input logic [6:0] f7, input logic [2:0] f3,
                                   input logic [6:0] op);
    return {f7, 5'd3, 5'd2, f3, 5'd1, op};       // rd x1, rs1 x2, rs2 x3
  endfunction

  function automatic instr_t enc_i(input logic [11:0] imm, input logic [2:0] f3,
                                   input logic [6:0] op);
    return {imm, 5'd2, f3, 5'd1, op};
  endfunction

  ////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////
  function automatic alu_op_e alu_ref(input logic [2:0] f3, input logic alt);
    case (f3)
      3'd0:    return alt ? SUB : ADD;
      3'd1:    return SLL;
      3'd2:    return SLT;
      3'd3:    return SLTU;
      3'd4:    return XOR;
      3'd5:    return alt ? SRA : SRL;
      3'd6:    return OR;
      default: return AND;
    endcase
  endfunction

  function automatic id_ex_pipe_t ref_decode(input instr_t w, input logic v,
                                             input logic illc, input logic kill);
    id_ex_pipe_t   r;
    decoder_ctrl_t c;
    logic [6:0]    op;
    logic [6:0]    f7;
    logic [2:0]    f3;
    logic          ok;
    op = w[6:0];
    f3 = w[14:12];
    f7 = w[31:25];
    c  = DECODER_CTRL_IDLE;
    ok = 1'b1;
    if ((op == OPC_OP) && (f7 == FUNCT7_MULDIV)) begin   // M wins over I
      c.rf_we = 1'b1;
      c.rf_re = 2'b11;
      if (f3 < 3'd4) begin
        c.mul_en = 1'b1;
        case (f3[1:0])
          2'd0:    c.mul_operator = MUL;
          2'd1:    c.mul_operator = MULH;
          2'd2:    c.mul_operator = MULHSU;
          default: c.mul_operator = MULHU;
        endcase
      end else begin
        c.div_en = 1'b1;
        case (f3[1:0])
          2'd0:    c.div_operator = DIV;
          2'd1:    c.div_operator = DIVU;
          2'd2:    c.div_operator = REM;
          default: c.div_operator = REMU;
        endcase
      end
    end else begin
      case (op)
        OPC_OP: begin
          c.alu_en = 1'b1;
          c.rf_we  = 1'b1;
          c.rf_re  = 2'b11;
          c.alu_operator = alu_ref(f3, f7 == 7'h20);
          ok = (f7 == 7'h00) || ((f7 == 7'h20) && ((f3 == 3'd0) || (f3 == 3'd5)));
        end
        OPC_OPIMM: begin
          c.alu_en = 1'b1;
          c.rf_we  = 1'b1;
          c.rf_re  = 2'b01;
          c.alu_operator = alu_ref(f3, (f3 == 3'd5) && (f7 == 7'h20));
          if (f3 == 3'd1) ok = (f7 == 7'h00);                  // SLLI
          if (f3 == 3'd5) ok = (f7 == 7'h00) || (f7 == 7'h20); // SRLI, SRAI
        end
        OPC_LUI, OPC_AUIPC: begin
          c.alu_en = 1'b1;
          c.rf_we  = 1'b1;
        end
        OPC_LOAD: begin
          c.lsu_en   = 1'b1;
          c.rf_we    = 1'b1;
          c.rf_re    = 2'b01;
          c.lsu_size = f3[1:0];
          c.lsu_sext = !f3[2];
          ok = !((f3 == 3'd3) || (f3 == 3'd6) || (f3 == 3'd7));
        end
        OPC_STORE: begin
          c.lsu_en   = 1'b1;
          c.lsu_we   = 1'b1;
          c.rf_re    = 2'b11;
          c.lsu_size = f3[1:0];
          ok = (f3 <= 3'd2);
        end
        OPC_SYSTEM: begin
          if (f3 == 3'd0) begin
            c.sys_en = 1'b1;
            case (w)
              32'h0000_0073: c.sys_ecall = 1'b1;
              32'h0010_0073: c.sys_ebrk  = 1'b1;
              32'h3020_0073: c.sys_mret  = 1'b1;
              32'h1050_0073: c.sys_wfi   = 1'b1;
              default:       ok = 1'b0;
            endcase
          end else if (f3 == 3'd4) begin
            ok = 1'b0;
          end else begin
            c.csr_en = 1'b1;
            c.rf_we  = 1'b1;
            c.rf_re  = f3[2] ? 2'b00 : 2'b01;                  // uimm forms
            if (f3[1:0] == 2'd1)      c.csr_op = CSR_WRITE;
            else if (w[19:15] == 5'd0) c.csr_op = CSR_READ;   // Set/clear with x0
            else if (f3[1:0] == 2'd2) c.csr_op = CSR_SET;
            else                      c.csr_op = CSR_CLEAR;
          end
        end
        OPC_MISCMEM: begin
          if (f3 == 3'd1) begin
            c.sys_en     = 1'b1;
            c.sys_fencei = 1'b1;
          end else if (f3 != 3'd0) begin
            ok = 1'b0;
          end
        end
        default: ok = 1'b0;
      endcase
    end
    if (!ok || illc) c = DECODER_CTRL_ILLEGAL_INSN;
    if (kill) begin
      {c.alu_en, c.mul_en, c.div_en, c.lsu_en} = 4'b0000;
      {c.csr_en, c.sys_en, c.rf_we, c.lsu_we}  = 4'b0000;
      c.illegal_insn = 1'b0;
    end
    if (!v) c = DECODER_CTRL_IDLE;                // Bubble
    r.valid = v;
    r.ctrl  = c;
    return r;
  endfunction

  ////////////////////////////////////////
  // Compare tasks
  ////////////////////////////////////////
  task automatic check_bit(input string name, input logic got, input logic exp);
    n_checks++;
    if (got !== exp) begin
      n_err++;
      $display("ERR %0t %s got %b exp %b", $time, name, got, exp);
    end
  endtask

  task automatic check_alu(input string name, input alu_op_e got, input alu_op_e exp);
    n_checks++;
    if (got !== exp) begin
      n_err++;
      $display("ERR %0t %s got %s exp %s", $time, name, got.name(), exp.name());
    end
  endtask

  task automatic check_mul(input string name, input mul_op_e got, input mul_op_e exp);
    n_checks++;
    if (got !== exp) begin
      n_err++;
      $display("ERR %0t %s got %s exp %s", $time, name, got.name(), exp.name());
    end
  endtask

  task automatic check_div(input string name, input div_op_e got, input div_op_e exp);
    n_checks++;
    if (got !== exp) begin
      n_err++;
      $display("ERR %0t %s got %s exp %s", $time, name, got.name(), exp.name());
    end
  endtask

  task automatic check_size(input string name, input lsu_size_t got, input lsu_size_t exp);
    n_checks++;
    if (got !== exp) begin
      n_err++;
      $display("ERR %0t %s got %0d exp %0d", $time, name, got, exp);
    end
  endtask

  task automatic check_csr(input string name, input csr_op_e got, input csr_op_e exp);
    n_checks++;
    if (got !== exp) begin
      n_err++;
      $display("ERR %0t %s got %s exp %s", $time, name, got.name(), exp.name());
    end
  endtask

  task automatic compare_pipe(input id_ex_pipe_t got, input id_ex_pipe_t exp);
    check_bit("valid", got.valid, exp.valid);
    check_bit("alu_en", got.ctrl.alu_en, exp.ctrl.alu_en);
    check_bit("mul_en", got.ctrl.mul_en, exp.ctrl.mul_en);
    check_bit("div_en", got.ctrl.div_en, exp.ctrl.div_en);
    check_bit("lsu_en", got.ctrl.lsu_en, exp.ctrl.lsu_en);
    check_bit("csr_en", got.ctrl.csr_en, exp.ctrl.csr_en);
    check_bit("sys_en", got.ctrl.sys_en, exp.ctrl.sys_en);
    check_bit("rf_we", got.ctrl.rf_we, exp.ctrl.rf_we);
    check_alu("alu_operator", got.ctrl.alu_operator, exp.ctrl.alu_operator);
    check_mul("mul_operator", got.ctrl.mul_operator, exp.ctrl.mul_operator);
    check_div("div_operator", got.ctrl.div_operator, exp.ctrl.div_operator);
    check_csr("csr_op", got.ctrl.csr_op, exp.ctrl.csr_op);
    check_bit("lsu_we", got.ctrl.lsu_we, exp.ctrl.lsu_we);
    check_size("lsu_size", got.ctrl.lsu_size, exp.ctrl.lsu_size);
    check_bit("lsu_sext", got.ctrl.lsu_sext, exp.ctrl.lsu_sext);
    check_bit("rf_re_rs1", got.ctrl.rf_re[0], exp.ctrl.rf_re[0]);
    check_bit("rf_re_rs2", got.ctrl.rf_re[1], exp.ctrl.rf_re[1]);
    check_bit("sys_ecall", got.ctrl.sys_ecall, exp.ctrl.sys_ecall);
    check_bit("sys_ebrk", got.ctrl.sys_ebrk, exp.ctrl.sys_ebrk);
    check_bit("sys_mret", got.ctrl.sys_mret, exp.ctrl.sys_mret);
    check_bit("sys_wfi", got.ctrl.sys_wfi, exp.ctrl.sys_wfi);
    check_bit("sys_fencei", got.ctrl.sys_fencei, exp.ctrl.sys_fencei);
    check_bit("illegal_insn", got.ctrl.illegal_insn, exp.ctrl.illegal_insn);
  endtask

  // Output is stable at the falling edge
  always @(negedge clk_i) begin
    id_ex_pipe_t exp;
    if ((due_q.size() != 0) && (due_q[0] == cycle)) begin
      exp = exp_q.pop_front();
      void'(due_q.pop_front());
      compare_pipe(id_ex_pipe_o, exp);
    end
  end

  ////////////////////////////////////////
  // Drive and sequence
  ////////////////////////////////////////
  // Kill reaches this word one edge later in its ID cycle
  task automatic step(input logic v, input instr_t w, input logic illc, input logic kill);
    @(posedge clk_i);
    instr_valid_i <= v;
    instr_i       <= w;
    illegal_c_i   <= illc;
    deassert_we_i <= prev_kill;
    prev_kill = kill;
    exp_q.push_back(ref_decode(w, v, illc, kill));
    due_q.push_back(cycle + 3);                  // Edge count after the 2nd edge
  endtask

  task automatic issue(input instr_t w);
    step(1'b1, w, 1'b0, 1'b0);
  endtask

  task automatic finish_test(input string name);
    step(1'b0, '0, 1'b0, 1'b0);
    step(1'b0, '0, 1'b0, 1'b0);
    while (due_q.size() != 0) @(negedge clk_i);
    n_tests++;
    $display("%-10s %0d errors", name, n_err - test_err);
    test_err = n_err;
  endtask

  task automatic test_alu();
    id_ex_pipe_t idle;
    idle.valid             = 1'b0;
    idle.ctrl              = DECODER_CTRL_ILLEGAL_INSN;
    idle.ctrl.illegal_insn = 1'b0;                           // Reset state
    @(negedge clk_i);
    compare_pipe(id_ex_pipe_o, idle);
    for (int i = 0; i < 8; i++) issue(enc_r(7'h00, i[2:0], OPC_OP));
    issue(enc_r(7'h20, 3'd0, OPC_OP));                       // SUB
    issue(enc_r(7'h20, 3'd5, OPC_OP));                       // SRA
    issue(enc_r(7'h20, 3'd1, OPC_OP));                       // Illegal funct7
    for (int i = 0; i < 8; i++) issue(enc_i(12'h005, i[2:0], OPC_OPIMM));
    issue(enc_i(12'h405, 3'd5, OPC_OPIMM));                  // SRAI
    issue(enc_i(12'h401, 3'd1, OPC_OPIMM));                  // Bad SLLI
    issue({20'h12345, 5'd1, OPC_LUI});
    issue({20'h00010, 5'd1, OPC_AUIPC});
    finish_test("alu");
  endtask

  task automatic test_muldiv();
    for (int i = 0; i < 8; i++) issue(enc_r(FUNCT7_MULDIV, i[2:0], OPC_OP));
    finish_test("muldiv");
  endtask

  task automatic test_lsu();
    for (int i = 0; i < 8; i++) issue(enc_i(12'h010, i[2:0], OPC_LOAD));
    for (int i = 0; i < 8; i++) issue(enc_r(7'h00, i[2:0], OPC_STORE));
    finish_test("lsu");
  endtask

  task automatic test_system();
    issue(32'h0000_0073);                                    // ECALL
    issue(32'h0010_0073);                                    // EBREAK
    issue(32'h3020_0073);                                    // MRET
    issue(32'h1050_0073);                                    // WFI
    issue(32'h0020_0073);                                    // Unknown SYSTEM word
    issue(32'h0000_100f);                                    // FENCE.I
    issue(32'h0ff0_000f);                                    // FENCE
    issue(enc_i(12'h000, 3'd2, OPC_MISCMEM));
    for (int i = 1; i < 8; i++) issue(enc_i(12'h300, i[2:0], OPC_SYSTEM));
    issue({12'h300, 5'd0, 3'd2, 5'd1, OPC_SYSTEM});          // CSRRS x0 reads
    issue(enc_i(12'h000, 3'd0, 7'h6f));                      // JAL out of scope
    issue(32'hffff_ffff);
    step(1'b1, enc_r(7'h00, 3'd0, OPC_OP), 1'b1, 1'b0);      // Bad compressed
    finish_test("system");
  endtask

  task automatic test_deassert();
    issue(enc_r(7'h00, 3'd0, OPC_OP));
    step(1'b1, enc_i(12'h010, 3'd2, OPC_LOAD), 1'b0, 1'b1);
    issue(enc_r(7'h00, 3'd4, OPC_OP));
    step(1'b1, 32'hffff_ffff, 1'b0, 1'b1);                   // Killed illegal
    step(1'b1, enc_r(7'h00, 3'd2, OPC_STORE), 1'b0, 1'b1);
    issue(enc_r(FUNCT7_MULDIV, 3'd5, OPC_OP));
    finish_test("deassert");
  endtask

  function automatic instr_t rand_word();
    logic [31:0] r;
    logic [2:0]  sel;
    logic [1:0]  f7sel;
    instr_t      w;
    w     = rand_bits(32);
    r     = rand_bits(3);
    sel   = r[2:0];
    r     = rand_bits(2);
    f7sel = r[1:0];
    case (sel)
      3'd0, 3'd1: w[6:0] = OPC_OP;
      3'd2:       w[6:0] = OPC_OPIMM;
      3'd3:       w[6:0] = OPC_LOAD;
      3'd4:       w[6:0] = OPC_STORE;
      3'd5:       w[6:0] = OPC_LUI;
      3'd6:       w[6:0] = OPC_SYSTEM;
      default:    w[6:0] = OPC_MISCMEM;
    endcase
    case (f7sel)                                             // Bias to legal funct7
      2'd0:    w[31:25] = 7'h00;
      2'd1:    w[31:25] = 7'h20;
      2'd2:    w[31:25] = FUNCT7_MULDIV;
      default: ;                                             // Random funct7 kept
    endcase
    return w;
  endfunction

  task automatic test_random();
    logic [31:0] r;
    logic        v;
    logic        illc;
    logic        kill;
    for (int i = 0; i < N_RAND; i++) begin
      r    = rand_bits(2);
      v    = (r[1:0] != 2'd0);                               // About 1 in 4 bubbles
      r    = rand_bits(4);
      illc = (r[3:0] == 4'd0);
      r    = rand_bits(3);
      kill = (r[2:0] == 3'd0);
      step(v, rand_word(), illc, kill);
    end
    finish_test("random");
  endtask

  initial begin
    rst_n_i       = 1'b0;
    instr_valid_i = 1'b0;
    instr_i       = '0;
    illegal_c_i   = 1'b0;
    deassert_we_i = 1'b0;
    test_err      = 0;
    repeat (3) @(posedge clk_i);
    rst_n_i <= 1'b1;
    test_alu();
    test_muldiv();
    test_lsu();
    test_system();
    test_deassert();
    test_random();
    $display("tests %0d, checks %0d, errors %0d", n_tests, n_checks, n_err);
    if (n_err == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

//--- build.f
dec_pkg.sv
if_id_stage.sv
i_decoder.sv
m_decoder.sv
decoder.sv
id_ex_stage.sv
decode_top.sv
decode_assert.sv
tb_decode.sv

//--- Makefile
# Verilator build and run of the decode testbench

LOG := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run tb_decode, check $(LOG)"
	@echo "  clean  remove obj_dir and $(LOG)"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -f build.f --top-module tb_decode \
		-Mdir obj_dir -o Vtb_decode
	./obj_dir/Vtb_decode > $(LOG) 2>&1
	@cat $(LOG)
	@! grep -qF '** FAIL **' $(LOG)

clean:
	rm -rf obj_dir $(LOG)
